/* logic/lbp_settings.svh */
`ifndef LBP_SETTINGS_SVH
`define LBP_SETTINGS_SVH

// datapath widths
`define PIXEL_WIDTH 8
`define WEIGHT_WIDTH 24 // FRAC_BITS + PIXEL_WIDTH so a weighted pixel never overflows
`define FRAC_BITS 16

// legal sampling radius
`define RADIUS_MIN 2
`define RADIUS_MAX 8

// host bus
`define AXI_ADDR_WIDTH 6
`define AXI_DATA_WIDTH 32

`endif

/* logic/lbpPkg.sv */
package lbpPkg;

    `include "lbp_settings.svh"

    typedef enum logic [1:0] {
        IDLE,
        ISSUE, // one diagonal angle per cycle
        DRAIN,
        FINISH
    } engineState;

    typedef enum logic [1:0] {
        ANG45,
        ANG135,
        ANG225,
        ANG315
    } sampleAngle;

    typedef enum logic [`AXI_ADDR_WIDTH-1:0] {
        CTRL    = 'h00,
        STATUS  = 'h04,
        CONFIG  = 'h08,
        CENTER  = 'h0C,
        AXIAL   = 'h10, // 0, 90, 180 and 270 degrees from low byte up
        CORN45  = 'h14,
        CORN135 = 'h18,
        CORN225 = 'h1C,
        CORN315 = 'h20,
        RESULT  = 'h24
    } regAddr;

endpackage

/* logic/interpWeightRom.sv */
`timescale 1ns/1ps
`include "lbp_settings.svh"

module interpWeightRom (
    input  logic [3:0]                radius,
    input  lbpPkg::sampleAngle        angle,
    output logic [`WEIGHT_WIDTH-1:0]  w1,
    output logic [`WEIGHT_WIDTH-1:0]  w2,
    output logic [`WEIGHT_WIDTH-1:0]  w3,
    output logic [`WEIGHT_WIDTH-1:0]  w4
);
    import lbpPkg::*;

    logic [`WEIGHT_WIDTH-1:0] p;
    logic [`WEIGHT_WIDTH-1:0] q;
    logic [`WEIGHT_WIDTH-1:0] r;

    // p weights the two pixels on the sample's own diagonal, q and r the others
    always_comb begin
        case (radius)
            4'd2: begin
                p = 'h3E1D;
                q = 'h57D8;
                r = 'h2BEC;
            end
            4'd3: begin
                p = 'h1B4A;
                q = 'hC5A6;
                r = 'h03C4;
            end
            4'd4: begin
                p = 'h2463;
                q = 'h0789;
                r = 'hAFB0;
            end
            4'd5: begin
                p = 'h3FAD;
                q = 'h3739;
                r = 'h496B;
            end
            4'd6: begin
                p = 'h2F0B;
                q = 'h92D6;
                r = 'h0F12;
            end
            4'd7: begin
                p = 'h0C37;
                q = 'h00A5;
                r = 'hE6EA;
            end
            4'd8: begin
                p = 'h39B3;
                q = 'h1E24;
                r = 'h6E73;
            end
            default: begin
                p = '0; // illegal radius gives an all-zero sample
                q = '0;
                r = '0;
            end
        endcase
    end

    // the same triple rotates through the four corner slots per quadrant
    always_comb begin
        case (angle)
            ANG45: begin
                w1 = p;
                w2 = q;
                w3 = r;
                w4 = p;
            end
            ANG135: begin
                w1 = r;
                w2 = p;
                w3 = p;
                w4 = q;
            end
            ANG225: begin
                w1 = p;
                w2 = r;
                w3 = q;
                w4 = p;
            end
            default: begin
                w1 = q;
                w2 = p;
                w3 = p;
                w4 = r;
            end
        endcase
    end

endmodule

/* logic/bilinearInterp.sv */
`timescale 1ns/1ps
`include "lbp_settings.svh"

module bilinearInterp (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inValid,
    input  lbpPkg::sampleAngle        inAngle,
    input  logic [`PIXEL_WIDTH-1:0]   a,
    input  logic [`PIXEL_WIDTH-1:0]   b,
    input  logic [`PIXEL_WIDTH-1:0]   c,
    input  logic [`PIXEL_WIDTH-1:0]   d,
    input  logic [`WEIGHT_WIDTH-1:0]  w1,
    input  logic [`WEIGHT_WIDTH-1:0]  w2,
    input  logic [`WEIGHT_WIDTH-1:0]  w3,
    input  logic [`WEIGHT_WIDTH-1:0]  w4,
    output logic                      outValid,
    output lbpPkg::sampleAngle        outAngle,
    output logic [`WEIGHT_WIDTH-1:0]  sample
);
    import lbpPkg::*;

    logic [`WEIGHT_WIDTH-1:0] prodA;
    logic [`WEIGHT_WIDTH-1:0] prodB;
    logic [`WEIGHT_WIDTH-1:0] prodC;
    logic [`WEIGHT_WIDTH-1:0] prodD;
    logic [`WEIGHT_WIDTH-1:0] sumAB;
    logic [`WEIGHT_WIDTH-1:0] sumCD;
    logic                     valid1;
    logic                     valid2;
    sampleAngle               angle1;
    sampleAngle               angle2;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid1   <= 1'b0;
            valid2   <= 1'b0;
            outValid <= 1'b0;
        end else begin
            valid1   <= inValid;
            valid2   <= valid1;
            outValid <= valid2;
        end
    end

    // weights never exceed 1.0 so the Q0.16 part times a pixel fits the word
    always_ff @(posedge clk) begin
        prodA    <= w1[`FRAC_BITS-1:0] * a;
        prodB    <= w2[`FRAC_BITS-1:0] * b;
        prodC    <= w3[`FRAC_BITS-1:0] * c;
        prodD    <= w4[`FRAC_BITS-1:0] * d;
        angle1   <= inAngle;
        sumAB    <= prodA + prodB;
        sumCD    <= prodC + prodD;
        angle2   <= angle1;
        sample   <= sumAB + sumCD;
        outAngle <= angle2;
    end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        outValid == $past(inValid, 3));

endmodule

/* logic/lbpEngine.sv */
`timescale 1ns/1ps
`include "lbp_settings.svh"

module lbpEngine (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [3:0]                  radius,
    input  logic [`PIXEL_WIDTH-1:0]     centre,
    input  logic [4*`PIXEL_WIDTH-1:0]   axial,
    input  logic [16*`PIXEL_WIDTH-1:0]  corners,
    output logic                        busy,
    output logic                        done,
    output logic                        radiusError,
    output logic [7:0]                  code,
    output logic                        issueValid,
    output lbpPkg::sampleAngle          issueAngle,
    output logic [`PIXEL_WIDTH-1:0]     a,
    output logic [`PIXEL_WIDTH-1:0]     b,
    output logic [`PIXEL_WIDTH-1:0]     c,
    output logic [`PIXEL_WIDTH-1:0]     d,
    input  logic                        resultValid,
    input  lbpPkg::sampleAngle          resultAngle,
    input  logic [`WEIGHT_WIDTH-1:0]    sample
);
    import lbpPkg::*;

    localparam logic [`WEIGHT_WIDTH:0] roundHalf = 1 << (`FRAC_BITS - 1);

    engineState                 state;
    sampleAngle                 angleReg;
    logic [2:0]                 resultCount;
    logic [7:0]                 codeWork;
    logic [7:0]                 axialBits;
    logic [`PIXEL_WIDTH-1:0]    centreReg;
    logic [4*`PIXEL_WIDTH-1:0]  cornerWord;
    logic [`WEIGHT_WIDTH:0]     roundedSum;
    logic                       radiusOk;

    assign radiusOk = (radius >= `RADIUS_MIN) && (radius <= `RADIUS_MAX);
    assign busy = (state != IDLE);
    assign issueValid = (state == ISSUE);
    assign issueAngle = angleReg;

    assign cornerWord = corners[int'(angleReg) * 4 * `PIXEL_WIDTH +: 4 * `PIXEL_WIDTH];
    assign a = cornerWord[0 +: `PIXEL_WIDTH];
    assign b = cornerWord[`PIXEL_WIDTH +: `PIXEL_WIDTH];
    assign c = cornerWord[2*`PIXEL_WIDTH +: `PIXEL_WIDTH];
    assign d = cornerWord[3*`PIXEL_WIDTH +: `PIXEL_WIDTH];

    assign roundedSum = {1'b0, sample} + roundHalf; // round to nearest before the shift

    // even code bits come straight from the axial pixels
    always_comb begin
        axialBits = '0;
        for (int i = 0; i < 4; i++) begin
            axialBits[2*i] = (axial[i*`PIXEL_WIDTH +: `PIXEL_WIDTH] >= centre);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            angleReg    <= ANG45;
            resultCount <= '0;
            done        <= 1'b0;
            radiusError <= 1'b0;
            code        <= '0;
        end else begin
            if (resultValid) begin
                resultCount <= resultCount + 3'd1;
            end
            case (state)
                IDLE: begin
                    if (start && radiusOk) begin
                        state       <= ISSUE;
                        angleReg    <= ANG45;
                        resultCount <= '0;
                        done        <= 1'b0;
                        radiusError <= 1'b0;
                    end else if (start) begin
                        done        <= 1'b1; // code keeps the previous job's value
                        radiusError <= 1'b1;
                    end
                end
                ISSUE: begin
                    angleReg <= sampleAngle'(angleReg + 2'd1);
                    if (angleReg == ANG315) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (resultCount == 3'd4) begin
                        state <= FINISH;
                    end
                end
                default: begin
                    code  <= codeWork;
                    done  <= 1'b1;
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            codeWork  <= axialBits;
            centreReg <= centre;
        end else if (resultValid) begin
            codeWork[{resultAngle, 1'b1}] <=
                (roundedSum[`WEIGHT_WIDTH:`FRAC_BITS] >= centreReg);
        end
    end

    a_noIssueInIdle: assert property (@(posedge clk) disable iff (rst)
        state == IDLE |=> !issueValid || $past(start));

    // all four results must land before the FSM returns to IDLE
    a_noResultInIdle: assert property (@(posedge clk) disable iff (rst)
        state == IDLE |-> !resultValid);

endmodule

/* logic/axiLiteRegs.sv */
`timescale 1ns/1ps
`include "lbp_settings.svh"

module axiLiteRegs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`AXI_ADDR_WIDTH-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`AXI_DATA_WIDTH-1:0]   wdata,
    input  logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`AXI_ADDR_WIDTH-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`AXI_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output logic                         start,
    output logic [3:0]                   radius,
    output logic [`PIXEL_WIDTH-1:0]      centre,
    output logic [4*`PIXEL_WIDTH-1:0]    axial,
    output logic [16*`PIXEL_WIDTH-1:0]   corners,
    input  logic                         busy,
    input  logic                         done,
    input  logic                         radiusError,
    input  logic [7:0]                   code
);
    import lbpPkg::*;

    logic                        writeFire;
    logic                        readFire;
    logic [`AXI_DATA_WIDTH-1:0]  readWord;

    assign writeFire = awready && awvalid && wvalid;
    assign readFire = arready && arvalid;
    assign bresp = 2'b00; // every access answers OKAY
    assign rresp = 2'b00;

    // wstrb is not decoded since only full-word writes are supported
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            start   <= 1'b0;
            radius  <= '0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            start   <= writeFire && (awaddr == CTRL) && wdata[0];
            if (writeFire) begin
                bvalid <= 1'b1;
                if (awaddr == CONFIG) begin
                    radius <= wdata[3:0];
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeFire) begin
            case (awaddr)
                CENTER:  centre <= wdata[`PIXEL_WIDTH-1:0];
                AXIAL:   axial <= wdata;
                CORN45:  corners[31:0] <= wdata;
                CORN135: corners[63:32] <= wdata;
                CORN225: corners[95:64] <= wdata;
                CORN315: corners[127:96] <= wdata;
                default: ; // CTRL and CONFIG live above, STATUS and RESULT are read only
            endcase
        end
    end

    always_comb begin
        case (araddr)
            STATUS:  readWord = {{(`AXI_DATA_WIDTH-3){1'b0}}, radiusError, done, busy};
            CONFIG:  readWord = {{(`AXI_DATA_WIDTH-4){1'b0}}, radius};
            CENTER:  readWord = {{(`AXI_DATA_WIDTH-`PIXEL_WIDTH){1'b0}}, centre};
            AXIAL:   readWord = axial;
            CORN45:  readWord = corners[31:0];
            CORN135: readWord = corners[63:32];
            CORN225: readWord = corners[95:64];
            CORN315: readWord = corners[127:96];
            RESULT:  readWord = {{(`AXI_DATA_WIDTH-8){1'b0}}, code};
            default: readWord = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (readFire) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1; // first cycle out of reset
        end
    end

    always_ff @(posedge clk) begin
        if (readFire) begin
            rdata <= readWord; // held until the host takes it
        end
    end

    a_bHold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid);

    a_rHold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* logic/lbpTop.sv */
`timescale 1ns/1ps
`include "lbp_settings.svh"

module lbpTop (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`AXI_ADDR_WIDTH-1:0]   awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`AXI_DATA_WIDTH-1:0]   wdata,
    input  logic [`AXI_DATA_WIDTH/8-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`AXI_ADDR_WIDTH-1:0]   araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`AXI_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready
);
    import lbpPkg::*;

    logic                        start;
    logic [3:0]                  radius;
    logic [`PIXEL_WIDTH-1:0]     centre;
    logic [4*`PIXEL_WIDTH-1:0]   axial;
    logic [16*`PIXEL_WIDTH-1:0]  corners;
    logic                        busy;
    logic                        done;
    logic                        radiusError;
    logic [7:0]                  code;
    logic                        issueValid;
    sampleAngle                  issueAngle;
    logic [`PIXEL_WIDTH-1:0]     pixA;
    logic [`PIXEL_WIDTH-1:0]     pixB;
    logic [`PIXEL_WIDTH-1:0]     pixC;
    logic [`PIXEL_WIDTH-1:0]     pixD;
    logic [`WEIGHT_WIDTH-1:0]    w1;
    logic [`WEIGHT_WIDTH-1:0]    w2;
    logic [`WEIGHT_WIDTH-1:0]    w3;
    logic [`WEIGHT_WIDTH-1:0]    w4;
    logic                        resultValid;
    sampleAngle                  resultAngle;
    logic [`WEIGHT_WIDTH-1:0]    sample;

    axiLiteRegs u_axiLiteRegs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .start(start), .radius(radius), .centre(centre), .axial(axial),
        .corners(corners), .busy(busy), .done(done),
        .radiusError(radiusError), .code(code)
    );

    lbpEngine u_lbpEngine (
        .clk(clk), .rst(rst), .start(start), .radius(radius),
        .centre(centre), .axial(axial), .corners(corners),
        .busy(busy), .done(done), .radiusError(radiusError), .code(code),
        .issueValid(issueValid), .issueAngle(issueAngle),
        .a(pixA), .b(pixB), .c(pixC), .d(pixD),
        .resultValid(resultValid), .resultAngle(resultAngle), .sample(sample)
    );

    // weights are looked up in the issue cycle, alongside the corner pixels
    interpWeightRom u_interpWeightRom (
        .radius(radius), .angle(issueAngle),
        .w1(w1), .w2(w2), .w3(w3), .w4(w4)
    );

    bilinearInterp u_bilinearInterp (
        .clk(clk), .rst(rst), .inValid(issueValid), .inAngle(issueAngle),
        .a(pixA), .b(pixB), .c(pixC), .d(pixD),
        .w1(w1), .w2(w2), .w3(w3), .w4(w4),
        .outValid(resultValid), .outAngle(resultAngle), .sample(sample)
    );

endmodule

/* tb/lbpTb.sv */
`timescale 1ns/1ps
`include "lbp_settings.svh"

module lbpTb;
    import lbpPkg::*;

    localparam int jobCount = 16;
    localparam int jobCycleLimit = 200;
    localparam int axiCyclesPerJob = 20 * 18; // ~20 transactions, each up to 18 cycles
    localparam int timeoutLimit = jobCount * (jobCycleLimit + axiCyclesPerJob) + 100;
    localparam int handshakeLimit = 32;

    logic                          clk;
    logic                          rst;
    logic [`AXI_ADDR_WIDTH-1:0]    awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [`AXI_DATA_WIDTH-1:0]    wdata;
    logic [`AXI_DATA_WIDTH/8-1:0]  wstrb;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [`AXI_ADDR_WIDTH-1:0]    araddr;
    logic                          arvalid;
    logic                          arready;
    logic [`AXI_DATA_WIDTH-1:0]    rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;

    int          checks = 0;
    int          errors = 0;
    int          cycleCount = 0;
    int          doneRiseCycle = -1;
    logic        donePrev = 1'b0;
    int          maxReadyDelay = 3;
    int unsigned lcgState = 54;

    // bilinear weight triples per radius, index 0, 1 unused
    int pTable [9] = '{0, 0, 'h3E1D, 'h1B4A, 'h2463, 'h3FAD, 'h2F0B, 'h0C37, 'h39B3};
    int qTable [9] = '{0, 0, 'h57D8, 'hC5A6, 'h0789, 'h3739, 'h92D6, 'h00A5, 'h1E24};
    int rTable [9] = '{0, 0, 'h2BEC, 'h03C4, 'hAFB0, 'h496B, 'h0F12, 'hE6EA, 'h6E73};

    lbpTop u_lbpTop (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
    end

    // records the cycle in which done goes high, sampled away from the edge
    always @(negedge clk) begin
        if (u_lbpTop.done && !donePrev) begin
            doneRiseCycle = cycleCount;
        end
        donePrev = u_lbpTop.done;
    end

    bHoldStable: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            errors++;
            $display("write response dropped or changed before bready");
        end

    rHoldStable: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            errors++;
            $display("read response dropped or changed before rready");
        end

    respOkay: assert property (@(posedge clk) disable iff (rst)
        (bvalid |-> bresp == 2'b00) and (rvalid |-> rresp == 2'b00))
        else begin
            errors++;
            $display("a response was not OKAY");
        end

    writeReadyPulse: assert property (@(posedge clk) disable iff (rst)
        (awready == wready) and (awready |=> !awready))
        else begin
            errors++;
            $display("awready and wready did not pulse together for one cycle");
        end

    function automatic logic [7:0] randByte();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:24]; // upper bits of the LCG are the least correlated
    endfunction

    function automatic logic [31:0] randWord();
        return {randByte(), randByte(), randByte(), randByte()};
    endfunction

    function automatic int randDelay();
        return int'(randByte()) % (maxReadyDelay + 1);
    endfunction

    // expected LBP code worked out from the weight table and the threshold rules
    function automatic logic [7:0] expectedCode(input int radius, input logic [7:0] centre,
                                                input logic [31:0] axial,
                                                input logic [127:0] corners);
        int p;
        int q;
        int r;
        int w [4];
        int sum;
        int value;
        logic [31:0] cornerWord;
        logic [7:0] codeOut;
        p = pTable[radius];
        q = qTable[radius];
        r = rTable[radius];
        codeOut = '0;
        for (int i = 0; i < 4; i++) begin
            codeOut[2*i] = (axial[8*i +: 8] >= centre);
        end
        for (int k = 0; k < 4; k++) begin
            case (k)
                0: w = '{p, q, r, p};
                1: w = '{r, p, p, q};
                2: w = '{p, r, q, p};
                default: w = '{q, p, p, r};
            endcase
            cornerWord = corners[32*k +: 32];
            sum = 0;
            for (int j = 0; j < 4; j++) begin
                sum += w[j] * int'(cornerWord[8*j +: 8]);
            end
            value = (sum + 'h8000) >>> 16;
            codeOut[2*k+1] = (value >= int'(centre));
        end
        return codeOut;
    endfunction

    task automatic checkEq(input string testName, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
        end
    endtask

    task automatic axiWrite(input logic [5:0] addr, input logic [31:0] data,
                            output int respCycle);
        int waitCount;
        int delay;
        respCycle = -1;
        @(posedge clk);
        #10;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        waitCount = 0;
        while (!awready && waitCount < handshakeLimit) begin
            @(negedge clk);
            waitCount++;
        end
        if (!awready) begin
            errors++;
            $display("write to 0x%0h was never accepted", addr);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            return;
        end
        @(posedge clk);
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waitCount = 0;
        while (!bvalid && waitCount < handshakeLimit) begin
            @(negedge clk);
            waitCount++;
        end
        if (!bvalid) begin
            errors++;
            $display("write to 0x%0h got no response", addr);
            return;
        end
        respCycle = cycleCount;
        delay = randDelay();
        repeat (delay) @(posedge clk);
        #10;
        bready = 1'b1;
        @(posedge clk);
        #10;
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [5:0] addr, output logic [31:0] data);
        int waitCount;
        int delay;
        data = '0;
        @(posedge clk);
        #10;
        araddr  = addr;
        arvalid = 1'b1;
        waitCount = 0;
        while (!arready && waitCount < handshakeLimit) begin
            @(negedge clk);
            waitCount++;
        end
        if (!arready) begin
            errors++;
            $display("read of 0x%0h was never accepted", addr);
            arvalid = 1'b0;
            return;
        end
        @(posedge clk);
        #10;
        arvalid = 1'b0;
        waitCount = 0;
        while (!rvalid && waitCount < handshakeLimit) begin
            @(negedge clk);
            waitCount++;
        end
        if (!rvalid) begin
            errors++;
            $display("read of 0x%0h got no response", addr);
            return;
        end
        delay = randDelay();
        repeat (delay) @(posedge clk);
        #10;
        rready = 1'b1;
        @(negedge clk);
        data = rdata;
        @(posedge clk);
        #10;
        rready = 1'b0;
    endtask

    task automatic readCheck(input string testName, input logic [5:0] addr,
                             input logic [31:0] expected);
        logic [31:0] data;
        axiRead(addr, data);
        checkEq(testName, expected, data);
    endtask

    task automatic runJob(input string testName, input int radius, input logic [7:0] centre,
                          input logic [31:0] axial, input logic [127:0] corners,
                          input bit doubleStart, output logic [7:0] codeRead);
        int respCycle;
        int otherCycle;
        int waitCount;
        logic [31:0] data;
        logic [7:0] expected;
        expected = expectedCode(radius, centre, axial, corners);
        axiWrite(CONFIG, radius, otherCycle);
        axiWrite(CENTER, centre, otherCycle);
        axiWrite(AXIAL, axial, otherCycle);
        for (int k = 0; k < 4; k++) begin
            axiWrite(6'(CORN45 + 4 * k), corners[32*k +: 32], otherCycle);
        end
        readCheck({testName, " config"}, CONFIG, radius);
        readCheck({testName, " centre"}, CENTER, centre);
        readCheck({testName, " axial"}, AXIAL, axial);
        for (int k = 0; k < 4; k++) begin
            readCheck($sformatf("%s corner%0d", testName, k), 6'(CORN45 + 4 * k),
                      corners[32*k +: 32]);
        end
        doneRiseCycle = -1;
        axiWrite(CTRL, 32'h1, respCycle);
        if (doubleStart) begin
            axiWrite(CTRL, 32'h1, otherCycle); // lands while the engine is busy
        end
        waitCount = 0;
        while (doneRiseCycle < 0 && waitCount < jobCycleLimit) begin
            @(posedge clk);
            waitCount++;
        end
        if (doneRiseCycle < 0) begin
            errors++;
            $display("%s: done did not rise within %0d cycles", testName, jobCycleLimit);
        end else begin
            checkEq({testName, " latency"}, 10, doneRiseCycle - respCycle);
        end
        axiRead(RESULT, data);
        checkEq({testName, " code"}, expected, data);
        codeRead = data[7:0];
        readCheck({testName, " status"}, STATUS, 32'h2);
    endtask

    initial begin
        while (cycleCount < timeoutLimit) begin
            @(negedge clk);
        end
        $display("timeout: run exceeded %0d cycles", timeoutLimit);
        $display("checks %0d, errors %0d", checks, errors);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [7:0] centre;
        logic [7:0] codeRead;
        logic [7:0] lastCode;
        logic [31:0] word;
        logic [127:0] corners;
        int illegal [3];
        int unusedCycle;
        illegal = '{0, 1, 9};
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        checkEq("resetOutputs", 0, {awready, wready, bvalid, rvalid, arready});
        rst = 1'b0;
        @(posedge clk);
        @(negedge clk);
        checkEq("arreadyRise", 1, arready);
        readCheck("resetStatus", STATUS, 0);
        readCheck("resetResult", RESULT, 0);

        // done and radiusError are both still low here, so the illegal start must set each
        axiWrite(CONFIG, 9, unusedCycle);
        axiWrite(CTRL, 32'h1, unusedCycle);
        readCheck("resetIllegal status", STATUS, 32'h6);
        readCheck("resetIllegal result", RESULT, 0);

        for (int radius = `RADIUS_MIN; radius <= `RADIUS_MAX; radius++) begin
            centre = randByte();
            word = randWord();
            corners = {randWord(), randWord(), randWord(), randWord()};
            runJob($sformatf("radius%0d", radius), radius, centre, word, corners, 0, codeRead);
        end

        centre = randByte();
        runJob("allEqual", 5, centre, {4{centre}}, {16{centre}}, 0, codeRead);
        checkEq("allEqual fixed", 8'hFF, codeRead);
        runJob("allZero", 3, 8'd1, '0, '0, 0, codeRead);
        checkEq("allZero fixed", 8'h00, codeRead);
        runJob("allMax", 7, 8'hFF, '1, '1, 0, codeRead);
        checkEq("allMax fixed", 8'hFF, codeRead);

        lastCode = codeRead;
        foreach (illegal[i]) begin
            axiWrite(CONFIG, illegal[i], unusedCycle);
            axiWrite(CTRL, 32'h1, unusedCycle);
            readCheck($sformatf("illegal%0d status", illegal[i]), STATUS, 32'h6);
            readCheck($sformatf("illegal%0d result", illegal[i]), RESULT, lastCode);
        end

        maxReadyDelay = 0; // keeps the second start inside the busy window
        word = randWord();
        corners = {randWord(), randWord(), randWord(), randWord()};
        runJob("doubleStart", 6, randByte(), word, corners, 1, codeRead);

        maxReadyDelay = 12;
        for (int i = 0; i < 6; i++) begin
            centre = randByte();
            axiWrite(CENTER, {24'h0, centre}, unusedCycle);
            readCheck($sformatf("backpressure centre%0d", i), CENTER, centre);
            word = randWord();
            axiWrite(CORN225, word, unusedCycle);
            readCheck($sformatf("backpressure corner%0d", i), CORN225, word);
        end
        word = randWord();
        corners = {randWord(), randWord(), randWord(), randWord()};
        runJob("backpressureJob", 4, randByte(), word, corners, 0, codeRead);

        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
logic/lbpPkg.sv
logic/interpWeightRom.sv
logic/bilinearInterp.sv
logic/lbpEngine.sv
logic/axiLiteRegs.sv
logic/lbpTop.sv
tb/lbpTb.sv
